// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module fm_tb -f sim.f --Mdir obj_dir
	./obj_dir/Vfm_tb | tee /dev/stderr | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

// ==== sim.f ====
+incdir+verilog
verilog/fm_pkg.sv
verilog/fm_bus_sync.sv
verilog/fm_regs.sv
verilog/fm_timers.sv
verilog/fm_lfo.sv
verilog/fm_core.sv
verif/fm_checker.sv
verif/fm_assert.sv
verif/fm_tb.sv

// ==== verif/fm_assert.sv ====
`default_nettype none

`include "fm_consts.svh"

module fm_assert (
	input wire clk_int,
	input wire rst_n,
	input wire irq_n,
	input wire flag_a,
	input wire flag_b,
	input wire clr_a,
	input wire clr_b,
	input wire busy
);

	irq_matches_flags: assert property (@(posedge clk_int) disable iff (!rst_n)
		irq_n == !(flag_a || flag_b))
		else $error("irq_n does not follow the timer flags");

	flag_a_cleared: assert property (@(posedge clk_int) disable iff (!rst_n)
		$fell(flag_a) |-> $past(clr_a))
		else $error("flag_a fell without a clear strobe");

	flag_b_cleared: assert property (@(posedge clk_int) disable iff (!rst_n)
		$fell(flag_b) |-> $past(clr_b))
		else $error("flag_b fell without a clear strobe");

	// Full busy length, checked from both ends
	busy_held: assert property (@(posedge clk_int) disable iff (!rst_n)
		$rose(busy) |-> ##(`FM_BUSY_CYCLES - 1) busy)
		else $error("busy fell early");

	busy_length: assert property (@(posedge clk_int) disable iff (!rst_n)
		$fell(busy) |-> $past(busy, `FM_BUSY_CYCLES))
		else $error("busy was shorter than its period");

endmodule

bind fm_core fm_assert u_assert (
	.clk_int ( clk_int     ),
	.rst_n   ( rst_n       ),
	.irq_n   ( irq_n       ),
	.flag_a  ( flag_a      ),
	.flag_b  ( flag_b      ),
	.clr_a   ( cfg.clr_a   ),
	.clr_b   ( cfg.clr_b   ),
	.busy    ( dout[7]     )
);

`default_nettype wire

// ==== verif/fm_checker.sv ====
`default_nettype none

module fm_checker (
	input  wire          clk_int,
	input  wire          req,
	input  wire  [7:0]   kind,
	input  wire  [127:0] name,
	input  wire  [15:0]  op_a,
	input  wire  [15:0]  op_b,
	input  wire  [7:0]   dout,
	input  wire          irq_n,
	input  wire  [6:0]   lfo_mod,
	output logic         done,
	output int           test_cnt,
	output int           err_cnt
);

	// Sampling on the falling edge keeps clear of register updates
	task automatic run_check();
		int         cnt;
		int         delta;
		logic [6:0] start;
		bit         ok;
		ok = 1'b1;
		test_cnt++;
		case (kind)
			"R": begin
				if ((dout & op_a[7:0]) != op_b[7:0]) begin
					$display("MISMATCH %0s expected %h actual %h", name, op_b[7:0],
						dout & op_a[7:0]);
					ok = 1'b0;
				end
			end
			"H": begin
				if (!irq_n) begin
					$display("MISMATCH %0s expected 1 actual 0", name);
					ok = 1'b0;
				end
			end
			"M": begin
				if (lfo_mod != op_a[6:0]) begin
					$display("MISMATCH %0s expected %0d actual %0d", name, op_a[6:0], lfo_mod);
					ok = 1'b0;
				end
			end
			"I": begin
				cnt = 0;
				while (irq_n && cnt < int'(op_b)) begin
					@(negedge clk_int);
					cnt++;
				end
				if (irq_n) begin
					$display("%0s: irq_n did not fall within %0d clocks", name, op_b);
					ok = 1'b0;
				end else if (cnt < int'(op_a)) begin
					$display("MISMATCH %0s expected at least %0d actual %0d", name, op_a, cnt);
					ok = 1'b0;
				end
			end
			"L": begin
				start = lfo_mod;
				repeat (op_a) @(negedge clk_int);
				delta = int'(7'(lfo_mod - start));
				if (delta < int'(op_b) - 1 || delta > int'(op_b) + 1) begin
					$display("MISMATCH %0s expected %0d actual %0d", name, op_b, delta);
					ok = 1'b0;
				end
			end
			default: begin
				$display("%0s: unknown check kind %s", name, kind);
				ok = 1'b0;
			end
		endcase
		if (!ok) begin
			err_cnt++;
		end
		$display("test %0s: %0s", name, ok ? "ok" : "error");
	endtask

	initial begin
		done     = 1'b0;
		test_cnt = 0;
		err_cnt  = 0;
		forever begin
			@(negedge clk_int);
			if (req && !done) begin
				run_check();
				done = 1'b1;
			end else if (!req) begin
				done = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verif/fm_stimulus.txt ====
# cmd name op1 op2 op3, operands in hex
# W/X write port data, N idle, B busy wait, A timer A, R/H/I/L/M checks
R reset_status ff 00 0
H reset_irq 0 0 0
M reset_lfo 0 0 0
A timer_a_irq 0 0 0
R timer_a_status ff 01 0
W sel_tb 0 26 0
W tb_value 1 fe 0
W sel_tctl 0 27 0
X start_b 1 1a 0
I timer_b_irq b4 d8 0
W clr_a_only 1 1a 0
R b_still_set 03 02 0
W stop_b 1 20 0
H irq_released 0 0 0
R flags_clear 03 00 0
W sel_tb2 0 26 0
X tb_keep 1 fe 0
N settle 3 0 0
R busy_bit 80 80 0
X tb_dropped 1 00 0
B busy_wait 0 0 0
W sel_tctl2 0 27 0
X restart_b 1 0a 0
I tb_old_period b4 d8 0
W stop_b2 1 20 0
W sel_tahi 0 24 0
W ta_hi 1 ff 0
W sel_talo 0 25 0
W ta_lo 1 03 0
W sel_tctl3 0 27 0
W run_a_no_flag 1 01 0
N overflow_wait 64 0 0
R no_flag_status ff 00 0
H no_flag_irq 0 0 0
W stop_a 1 00 0
W sel_lfo 0 22 0
W lfo_on 1 0f 0
L lfo_rate 190 32 0
W lfo_off 1 00 0
M lfo_zero 0 0 0

// ==== verif/fm_tb.sv ====
`default_nettype none

`include "fm_consts.svh"

module fm_tb;

	logic         clk_int = 1'b0;
	logic         rst_n;
	logic         cs_n;
	logic         wr_n;
	logic [1:0]   addr;
	logic [7:0]   din;
	logic [7:0]   dout;
	logic         irq_n;
	logic [6:0]   lfo_mod;
	logic         req;
	logic [7:0]   kind;
	logic [127:0] name;
	logic [15:0]  op_a;
	logic [15:0]  op_b;
	logic         done;
	int           test_cnt;
	int           err_cnt;
	bit           timed_out;
	integer       fd;
	integer       seed;
	integer       rc;
	int           value_a;
	int           period;
	logic [31:0]  cmd;
	logic [127:0] tname;
	logic [15:0]  a;
	logic [15:0]  b;
	logic [15:0]  c;
	string        line;

	fm_core dut (
		.clk_int ( clk_int ),
		.rst_n   ( rst_n   ),
		.cs_n    ( cs_n    ),
		.wr_n    ( wr_n    ),
		.addr    ( addr    ),
		.din     ( din     ),
		.dout    ( dout    ),
		.irq_n   ( irq_n   ),
		.lfo_mod ( lfo_mod )
	);

	fm_checker u_checker (
		.clk_int  ( clk_int  ),
		.req      ( req      ),
		.kind     ( kind     ),
		.name     ( name     ),
		.op_a     ( op_a     ),
		.op_b     ( op_b     ),
		.dout     ( dout     ),
		.irq_n    ( irq_n    ),
		.lfo_mod  ( lfo_mod  ),
		.done     ( done     ),
		.test_cnt ( test_cnt ),
		.err_cnt  ( err_cnt  )
	);

	always #2 clk_int = ~clk_int;

	// Each task returns one time unit after a rising edge
	task automatic idle(input int n);
		repeat (n) @(posedge clk_int);
		#1;
	endtask

	task automatic bus_write(input logic [1:0] port, input logic [7:0] data);
		addr = port;
		din  = data;
		cs_n = 1'b0;
		wr_n = 1'b0;
		idle(2);
		cs_n = 1'b1;
		wr_n = 1'b1;
		// Give the write time to reach the timer and LFO settings
		idle(3);
	endtask

	task automatic wait_not_busy();
		int i;
		i = 0;
		idle(3);
		while (dout[7] && i < 200) begin
			idle(1);
			i++;
		end
		if (dout[7]) begin
			$display("Busy bit never cleared");
			timed_out = 1'b1;
		end
	endtask

	task automatic request_check(input logic [7:0] k, input logic [127:0] nm,
		input logic [15:0] x, input logic [15:0] y);
		int i;
		i    = 0;
		kind = k;
		name = nm;
		op_a = x;
		op_b = y;
		req  = 1'b1;
		while (!done && i < 20000) begin
			idle(1);
			i++;
		end
		req = 1'b0;
		if (!done) begin
			$display("Checker gave no answer for %0s", nm);
			timed_out = 1'b1;
		end
		idle(1);
	endtask

	// Timer A with a random value, expected window from the tick count
	task automatic timer_a_random(input logic [127:0] nm);
		value_a = {$random(seed)} % 900;
		period  = (1024 - value_a) * `FM_TICK_DIV;
		bus_write(2'd0, `FM_REG_TA_HI);
		bus_write(2'd1, 8'(value_a >> 2));
		wait_not_busy();
		bus_write(2'd0, `FM_REG_TA_LO);
		bus_write(2'd1, 8'(value_a & 3));
		wait_not_busy();
		bus_write(2'd0, `FM_REG_TCTL);
		bus_write(2'd1, 8'h05);
		request_check("I", nm, 16'(period - 6), 16'(period + 6));
	endtask

	initial begin
		rst_n     = 1'b0;
		cs_n      = 1'b1;
		wr_n      = 1'b1;
		addr      = '0;
		din       = '0;
		req       = 1'b0;
		kind      = '0;
		name      = '0;
		op_a      = '0;
		op_b      = '0;
		timed_out = 1'b0;
		seed      = 97229;
		repeat (16) @(posedge clk_int);
		#1;
		rst_n = 1'b1;
		idle(2);
		fd = $fopen("verif/fm_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the stimulus file");
			timed_out = 1'b1;
		end
		while (!timed_out && $fscanf(fd, "%s", cmd) == 1) begin
			if (cmd == "#") begin
				rc = $fgets(line, fd);
			end else begin
				rc = $fscanf(fd, " %s %h %h %h", tname, a, b, c);
				case (cmd)
					"W": begin
						bus_write(a[1:0], b[7:0]);
						wait_not_busy();
					end
					"X": bus_write(a[1:0], b[7:0]);
					"N": idle(int'(a));
					"B": wait_not_busy();
					"A": timer_a_random(tname);
					default: request_check(cmd[7:0], tname, a, b);
				endcase
			end
		end
		$display("%0d tests run, %0d failed", test_cnt, err_cnt);
		if (!timed_out && err_cnt == 0 && test_cnt > 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/fm_bus_sync.sv ====
`default_nettype none

`include "fm_consts.svh"

module fm_bus_sync (
	input  wire              clk_int,
	input  wire              rst_n,
	input  wire              cs_n,
	input  wire              wr_n,
	input  wire  [1:0]       addr,
	input  wire  [7:0]       din,
	input  wire              flag_a,
	input  wire              flag_b,
	output fm_pkg::bus_wr_t  wr,
	output logic [7:0]       dout
);

	localparam int BUSY_W = $clog2(`FM_BUSY_CYCLES + 1);

	logic              cs_n_q;
	logic              wr_n_q;
	logic              wr_n_qq;
	logic [1:0]        addr_q;
	logic [7:0]        din_q;
	fm_pkg::bus_wr_t   pend;
	logic [BUSY_W-1:0] busy_cnt;
	logic              busy;

	assign busy = (busy_cnt != '0);

	// Input register and write edge capture
	always_ff @(posedge clk_int or negedge rst_n) begin
		if (!rst_n) begin
			cs_n_q  <= 1'b1;
			wr_n_q  <= 1'b1;
			wr_n_qq <= 1'b1;
			addr_q  <= '0;
			din_q   <= '0;
			pend    <= '0;
		end else begin
			cs_n_q     <= cs_n;
			wr_n_q     <= wr_n;
			wr_n_qq    <= wr_n_q;
			addr_q     <= addr;
			din_q      <= din;
			pend.valid <= wr_n_qq & ~wr_n_q & ~cs_n_q;
			pend.addr  <= addr_q;
			pend.data  <= din_q;
		end
	end

	// Data port writes are dropped while busy
	always_ff @(posedge clk_int or negedge rst_n) begin
		if (!rst_n) begin
			wr <= '0;
		end else begin
			wr.valid <= pend.valid & ((pend.addr != `FM_PORT_DATA) | ~busy);
			wr.addr  <= pend.addr;
			wr.data  <= pend.data;
		end
	end

	// Busy period, starts the cycle after an accepted data write
	always_ff @(posedge clk_int or negedge rst_n) begin
		if (!rst_n) begin
			busy_cnt <= '0;
		end else if (wr.valid && wr.addr == `FM_PORT_DATA) begin
			busy_cnt <= BUSY_W'(`FM_BUSY_CYCLES);
		end else if (busy) begin
			busy_cnt <= busy_cnt - 1'b1;
		end
	end

	assign dout = {busy, 5'b00000, flag_b, flag_a};

endmodule

`default_nettype wire

// ==== verilog/fm_consts.svh ====
`ifndef FM_CONSTS_SVH
`define FM_CONSTS_SVH

// Host port addresses
`define FM_PORT_ADDR 2'd0
`define FM_PORT_DATA 2'd1

// Register numbers
`define FM_REG_LFO   8'h22
`define FM_REG_TA_HI 8'h24
`define FM_REG_TA_LO 8'h25
`define FM_REG_TB    8'h26
`define FM_REG_TCTL  8'h27

// Clocks the chip stays busy after a data write
`define FM_BUSY_CYCLES 32

// Timer time base
`define FM_TICK_DIV    6
`define FM_TB_PRESCALE 16

// Clocks per LFO step, one per frequency code
`define FM_LFO_DIV0 108
`define FM_LFO_DIV1 77
`define FM_LFO_DIV2 71
`define FM_LFO_DIV3 67
`define FM_LFO_DIV4 62
`define FM_LFO_DIV5 44
`define FM_LFO_DIV6 32
`define FM_LFO_DIV7 8

`endif

// ==== verilog/fm_core.sv ====
`default_nettype none

module fm_core (
	input  wire        clk_int,
	input  wire        rst_n,
	input  wire        cs_n,
	input  wire        wr_n,
	input  wire  [1:0] addr,
	input  wire  [7:0] din,
	output logic [7:0] dout,
	output logic       irq_n,
	output logic [6:0] lfo_mod
);

	fm_pkg::bus_wr_t    wr;
	fm_pkg::timer_cfg_t cfg;
	fm_pkg::lfo_ctrl_t  lfo_cfg;
	logic               flag_a;
	logic               flag_b;

	// Host interface and status byte
	fm_bus_sync u_bus_sync (
		.clk_int ( clk_int ),
		.rst_n   ( rst_n   ),
		.cs_n    ( cs_n    ),
		.wr_n    ( wr_n    ),
		.addr    ( addr    ),
		.din     ( din     ),
		.flag_a  ( flag_a  ),
		.flag_b  ( flag_b  ),
		.wr      ( wr      ),
		.dout    ( dout    )
	);

	fm_regs u_regs (
		.clk_int ( clk_int ),
		.rst_n   ( rst_n   ),
		.wr      ( wr      ),
		.cfg     ( cfg     ),
		.lfo_cfg ( lfo_cfg )
	);

	fm_timers u_timers (
		.clk_int ( clk_int ),
		.rst_n   ( rst_n   ),
		.cfg     ( cfg     ),
		.flag_a  ( flag_a  ),
		.flag_b  ( flag_b  ),
		.irq_n   ( irq_n   )
	);

	// Modulation word brought out directly
	fm_lfo u_lfo (
		.clk_int ( clk_int ),
		.rst_n   ( rst_n   ),
		.lfo_cfg ( lfo_cfg ),
		.lfo_mod ( lfo_mod )
	);

endmodule

`default_nettype wire

// ==== verilog/fm_lfo.sv ====
`default_nettype none

`include "fm_consts.svh"

module fm_lfo (
	input  wire                clk_int,
	input  wire                rst_n,
	input  fm_pkg::lfo_ctrl_t  lfo_cfg,
	output logic [6:0]         lfo_mod
);

	logic [6:0] div_lim;
	logic [6:0] step_cnt;
	logic       step;

	// Step length per frequency code
	always_comb begin
		case (lfo_cfg.freq)
			3'd0:    div_lim = 7'(`FM_LFO_DIV0);
			3'd1:    div_lim = 7'(`FM_LFO_DIV1);
			3'd2:    div_lim = 7'(`FM_LFO_DIV2);
			3'd3:    div_lim = 7'(`FM_LFO_DIV3);
			3'd4:    div_lim = 7'(`FM_LFO_DIV4);
			3'd5:    div_lim = 7'(`FM_LFO_DIV5);
			3'd6:    div_lim = 7'(`FM_LFO_DIV6);
			default: div_lim = 7'(`FM_LFO_DIV7);
		endcase
	end

	// Greater-or-equal covers a switch to a faster code mid-count
	assign step = (step_cnt >= div_lim - 7'd1);

	always_ff @(posedge clk_int or negedge rst_n) begin
		if (!rst_n) begin
			step_cnt <= '0;
			lfo_mod  <= '0;
		end else if (!lfo_cfg.en) begin
			step_cnt <= '0;
			lfo_mod  <= '0;
		end else if (step) begin
			step_cnt <= '0;
			lfo_mod  <= lfo_mod + 7'd1;
		end else begin
			step_cnt <= step_cnt + 7'd1;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/fm_pkg.sv ====
`default_nettype none

package fm_pkg;

	// One host write, as seen after edge detection
	typedef struct packed {
		logic       valid;
		logic [1:0] addr;
		logic [7:0] data;
	} bus_wr_t;

	// Layout of the timer control register
	typedef struct packed {
		logic [1:0] unused;
		logic       clr_b;
		logic       clr_a;
		logic       flag_en_b;
		logic       flag_en_a;
		logic       run_b;
		logic       run_a;
	} timer_ctrl_t;

	// Layout of the LFO register
	typedef struct packed {
		logic [3:0] unused;
		logic       en;
		logic [2:0] freq;
	} lfo_ctrl_t;

	// Data byte, read according to the selected register
	typedef union packed {
		logic [7:0]  raw;
		timer_ctrl_t tctl;
		lfo_ctrl_t   lfo;
	} reg_byte_u;

	// Timer settings as held by the register block
	typedef struct packed {
		logic [9:0] value_a;
		logic [7:0] value_b;
		logic       run_a;
		logic       run_b;
		logic       flag_en_a;
		logic       flag_en_b;
		// Single-cycle strobes
		logic       clr_a;
		logic       clr_b;
	} timer_cfg_t;

endpackage

`default_nettype wire

// ==== verilog/fm_regs.sv ====
`default_nettype none

`include "fm_consts.svh"

module fm_regs (
	input  wire                 clk_int,
	input  wire                 rst_n,
	input  fm_pkg::bus_wr_t     wr,
	output fm_pkg::timer_cfg_t  cfg,
	output fm_pkg::lfo_ctrl_t   lfo_cfg
);

	logic [7:0]        reg_num;
	fm_pkg::reg_byte_u wr_byte;
	logic              addr_wr;
	logic              data_wr;

	assign wr_byte.raw = wr.data;
	assign addr_wr     = wr.valid && (wr.addr == `FM_PORT_ADDR);
	assign data_wr     = wr.valid && (wr.addr == `FM_PORT_DATA);

	// Register number from the address port
	always_ff @(posedge clk_int or negedge rst_n) begin
		if (!rst_n) begin
			reg_num <= '0;
		end else if (addr_wr) begin
			reg_num <= wr.data;
		end
	end

	// Timer settings
	always_ff @(posedge clk_int or negedge rst_n) begin
		if (!rst_n) begin
			cfg <= '0;
		end else begin
			// Clear bits only last one cycle
			cfg.clr_a <= 1'b0;
			cfg.clr_b <= 1'b0;
			if (data_wr) begin
				case (reg_num)
					`FM_REG_TA_HI: begin
						cfg.value_a[9:2] <= wr.data;
					end
					`FM_REG_TA_LO: begin
						cfg.value_a[1:0] <= wr.data[1:0];
					end
					`FM_REG_TB: begin
						cfg.value_b <= wr.data;
					end
					`FM_REG_TCTL: begin
						cfg.run_a     <= wr_byte.tctl.run_a;
						cfg.run_b     <= wr_byte.tctl.run_b;
						cfg.flag_en_a <= wr_byte.tctl.flag_en_a;
						cfg.flag_en_b <= wr_byte.tctl.flag_en_b;
						cfg.clr_a     <= wr_byte.tctl.clr_a;
						cfg.clr_b     <= wr_byte.tctl.clr_b;
					end
					default: begin
					end
				endcase
			end
		end
	end

	// LFO control, the spare bits stay zero
	always_ff @(posedge clk_int or negedge rst_n) begin
		if (!rst_n) begin
			lfo_cfg <= '0;
		end else if (data_wr && reg_num == `FM_REG_LFO) begin
			lfo_cfg.en   <= wr_byte.lfo.en;
			lfo_cfg.freq <= wr_byte.lfo.freq;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/fm_timers.sv ====
`default_nettype none

`include "fm_consts.svh"

module fm_timers (
	input  wire                 clk_int,
	input  wire                 rst_n,
	input  fm_pkg::timer_cfg_t  cfg,
	output logic                flag_a,
	output logic                flag_b,
	output logic                irq_n
);

	localparam int TICK_W = $clog2(`FM_TICK_DIV);
	localparam int PRE_W  = $clog2(`FM_TB_PRESCALE);
	localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(`FM_TICK_DIV - 1);
	localparam logic [PRE_W-1:0]  PRE_LAST  = PRE_W'(`FM_TB_PRESCALE - 1);

	logic [TICK_W-1:0] tick_cnt;
	logic              tick;
	logic [PRE_W-1:0]  pre_cnt;
	logic              step_b;
	logic              run_a_q;
	logic              run_b_q;
	logic              load_a;
	logic              load_b;
	logic [9:0]        cnt_a;
	logic [7:0]        cnt_b;
	logic              ovf_a;
	logic              ovf_b;

	// Free-running time base
	always_ff @(posedge clk_int or negedge rst_n) begin
		if (!rst_n) begin
			tick_cnt <= '0;
		end else if (tick) begin
			tick_cnt <= '0;
		end else begin
			tick_cnt <= tick_cnt + 1'b1;
		end
	end

	assign tick   = (tick_cnt == TICK_LAST);
	assign step_b = tick && (pre_cnt == PRE_LAST);
	assign load_a = cfg.run_a & ~run_a_q;
	assign load_b = cfg.run_b & ~run_b_q;
	assign ovf_a  = cfg.run_a && !load_a && tick && (cnt_a == '1);
	assign ovf_b  = cfg.run_b && !load_b && step_b && (cnt_b == '1);

	always_ff @(posedge clk_int or negedge rst_n) begin
		if (!rst_n) begin
			run_a_q <= 1'b0;
			run_b_q <= 1'b0;
			pre_cnt <= '0;
			cnt_a   <= '0;
			cnt_b   <= '0;
		end else begin
			run_a_q <= cfg.run_a;
			run_b_q <= cfg.run_b;
			// Prescaler phase follows the B run bit
			if (!cfg.run_b) begin
				pre_cnt <= '0;
			end else if (tick) begin
				pre_cnt <= pre_cnt + 1'b1;
			end
			if (load_a || ovf_a) begin
				cnt_a <= cfg.value_a;
			end else if (cfg.run_a && tick) begin
				cnt_a <= cnt_a + 1'b1;
			end
			if (load_b || ovf_b) begin
				cnt_b <= cfg.value_b;
			end else if (cfg.run_b && step_b) begin
				cnt_b <= cnt_b + 1'b1;
			end
		end
	end

	// Flags hold until cleared
	always_ff @(posedge clk_int or negedge rst_n) begin
		if (!rst_n) begin
			flag_a <= 1'b0;
			flag_b <= 1'b0;
		end else begin
			if (cfg.clr_a) begin
				flag_a <= 1'b0;
			end else if (ovf_a && cfg.flag_en_a) begin
				flag_a <= 1'b1;
			end
			if (cfg.clr_b) begin
				flag_b <= 1'b0;
			end else if (ovf_b && cfg.flag_en_b) begin
				flag_b <= 1'b1;
			end
		end
	end

	assign irq_n = ~(flag_a | flag_b);

endmodule

`default_nettype wire
